/* project.f */
+incdir+include
logic/misc_pkg.sv
logic/misc_operand_stage.sv
logic/misc_shift_clamp_stage.sv
logic/misc_result_stage.sv
logic/misc_branch.sv
test/misc_branch_checker.sv
test/tb_misc_branch.sv

/* Bender.yml */
package:
  name: misc_branch

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/misc_pkg.sv
      - logic/misc_operand_stage.sv
      - logic/misc_shift_clamp_stage.sv
      - logic/misc_result_stage.sv
      - logic/misc_branch.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/misc_branch_checker.sv
      - test/tb_misc_branch.sv

/* test/tb_misc_branch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "misc_cfg.svh"

module tb_misc_branch;
	import misc_pkg::*;

	localparam int RANDOM_ROWS = 200;
	localparam logic [31:0] SEED = 32'h83d0;

	typedef struct packed {
		misc_op_e op;
		logic signed [`MISC_DATA_WIDTH-1:0] a;
		logic signed [`MISC_DATA_WIDTH-1:0] b;
		logic signed [`MISC_DATA_WIDTH-1:0] c;
		acc_word_u acc;
		logic [`MISC_SHIFT_WIDTH-1:0] sh;
		logic [`MISC_DEST_WIDTH-1:0] dest;
		logic signed [`MISC_FULL_WIDTH-1:0] exp;
	} row_t;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	logic out_valid;
	logic out_ready;
	logic signed [`MISC_FULL_WIDTH-1:0] result;
	logic [`MISC_DEST_WIDTH-1:0] dest_out;
	row_t cur; // row on the DUT inputs.
	row_t rows [$];
	int checked;
	int errors;
	int idle_errors;
	logic [31:0] rand_state;
	logic [31:0] bp_state;

	misc_branch misc_branch_inst (
		.clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
		.op(cur.op), .arg_a(cur.a), .arg_b(cur.b), .arg_c(cur.c),
		.accumulator(cur.acc), .shift(cur.sh), .dest(cur.dest),
		.out_valid(out_valid), .out_ready(out_ready),
		.result(result), .dest_out(dest_out)
	);

	misc_branch_checker checker_inst (
		.clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
		.dest(cur.dest), .exp_result(cur.exp),
		.out_valid(out_valid), .out_ready(out_ready),
		.result(result), .dest_out(dest_out),
		.checked(checked), .errors(errors), .idle_errors(idle_errors)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic signed [`MISC_FULL_WIDTH-1:0] expected_result(
		input misc_op_e op,
		input logic signed [`MISC_DATA_WIDTH-1:0] a,
		input logic signed [`MISC_DATA_WIDTH-1:0] b,
		input logic signed [`MISC_DATA_WIDTH-1:0] c,
		input acc_word_u acc,
		input logic [`MISC_SHIFT_WIDTH-1:0] sh
	);
		logic signed [`MISC_DATA_WIDTH-1:0] v;
		case (op)
			op_lsh:      v = a << sh; // bits above 16 drop out.
			op_rsh:      v = $unsigned(a) >> sh;
			op_abs:      v = (a < 0) ? -a : a;
			op_min:      v = (a < b) ? a : b;
			op_max:      v = (a < b) ? b : a;
			op_clamp:    v = (b < c) ? ((a < b) ? b : ((a > c) ? c : a)) :
				((a < c) ? c : ((a > b) ? b : a));
			op_mov_acc:  return {{`MISC_ACC_SHIFT{acc.word[`MISC_FULL_WIDTH-1]}},
				acc.word[`MISC_FULL_WIDTH-1:`MISC_ACC_SHIFT]};
			op_mov_uacc: v = acc.word[31:16];
			op_mov_lacc: v = acc.word[15:0];
			default:     v = '0;
		endcase
		return v; // signed, so it widens with its sign.
	endfunction

	function automatic row_t make_row(input misc_op_e op, input int a, input int b, input int c,
		input logic [`MISC_FULL_WIDTH-1:0] acc, input int sh, input int exp);
		row_t r;
		r.op = op;
		r.a = a[`MISC_DATA_WIDTH-1:0];
		r.b = b[`MISC_DATA_WIDTH-1:0];
		r.c = c[`MISC_DATA_WIDTH-1:0];
		r.acc = acc;
		r.sh = sh[`MISC_SHIFT_WIDTH-1:0];
		r.dest = 4'(rows.size());
		r.exp = exp;
		return r;
	endfunction

	function automatic row_t with_expected(input row_t r);
		r.exp = expected_result(r.op, r.a, r.b, r.c, r.acc, r.sh);
		return r;
	endfunction

	task automatic build_table();
		rows.push_back(make_row(op_lsh, 1, 0, 0, 0, 15, -32768));
		rows.push_back(make_row(op_lsh, 'h00ff, 0, 0, 0, 12, -4096));
		rows.push_back(make_row(op_rsh, -32768, 0, 0, 0, 15, 1));
		rows.push_back(make_row(op_rsh, 'hff00, 0, 0, 0, 4, 4080));
		rows.push_back(make_row(op_abs, -5, 0, 0, 0, 0, 5));
		rows.push_back(make_row(op_abs, -32768, 0, 0, 0, 0, -32768));
		rows.push_back(make_row(op_abs, 1234, 0, 0, 0, 0, 1234));
		rows.push_back(make_row(op_min, -3, 7, 0, 0, 0, -3));
		rows.push_back(make_row(op_min, 9, 9, 0, 0, 0, 9));
		rows.push_back(make_row(op_max, -3, -7, 0, 0, 0, -3));
		rows.push_back(make_row(op_max, -32768, 32767, 0, 0, 0, 32767));
		rows.push_back(make_row(op_max, 4, 4, 0, 0, 0, 4));
		rows.push_back(make_row(op_clamp, 50, 10, 20, 0, 0, 20));
		rows.push_back(make_row(op_clamp, 50, 20, 10, 0, 0, 20));
		rows.push_back(make_row(op_clamp, -50, 20, -10, 0, 0, -10));
		rows.push_back(make_row(op_clamp, 5, 10, -10, 0, 0, 5));
		rows.push_back(make_row(op_mov_acc, 0, 0, 0, 40'h00_0000_8000, 0, 1));
		rows.push_back(make_row(op_mov_acc, 0, 0, 0, 40'h80_0000_0000, 0, -16777216));
		rows.push_back(make_row(op_mov_uacc, 0, 0, 0, 40'h12_8765_4321, 0, -30875));
		rows.push_back(make_row(op_mov_lacc, 0, 0, 0, 40'h12_8765_4321, 0, 17185));
		for (int s = 0; s < 16; s++) begin
			rows.push_back(with_expected(make_row(op_lsh, 'h9a5b, 0, 0, 0, s, 0)));
			rows.push_back(with_expected(make_row(op_rsh, 'h9a5b, 0, 0, 0, s, 0)));
		end
	endtask

	task automatic random_row(output row_t r);
		logic [31:0] w [4];
		for (int i = 0; i < 4; i++) begin
			rand_state = xorshift32(rand_state);
			w[i] = rand_state;
		end
		r = make_row(misc_op_e'(4'(w[0] % 9)), w[1][15:0], w[1][31:16], w[2][15:0],
			{w[2][31:24], w[3]}, w[2][19:16], 0);
		r.dest = w[0][31:28];
		r = with_expected(r);
	endtask

	// returns at the edge where the DUT took the row.
	task automatic apply_row(input row_t r);
		cur <= r;
		in_valid <= 1'b1;
		@(posedge clk);
		while (!in_ready) @(posedge clk);
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin : back_pressure
		bp_state = ~SEED;
		out_ready = 1'b1;
		forever begin
			@(posedge clk);
			bp_state = xorshift32(bp_state);
			out_ready <= (bp_state[1:0] != 2'b00); // low one cycle in four.
		end
	end

	initial begin : watchdog
		@(negedge reset);
		#((rows.size() + RANDOM_ROWS) * 20 * 8);
		$display("Timeout: the DUT did not return every item in time");
		$display("Some tests failed");
		$finish;
	end

	initial begin : stimulus
		row_t r;
		reset = 1'b1;
		in_valid = 1'b0;
		cur = '0;
		rand_state = SEED;
		build_table();
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		repeat (4) @(posedge clk); // idle window with no input.
		foreach (rows[i]) apply_row(rows[i]);
		for (int i = 0; i < RANDOM_ROWS; i++) begin
			random_row(r);
			apply_row(r);
		end
		in_valid <= 1'b0;
		wait (checked == rows.size() + RANDOM_ROWS);
		repeat (10) @(posedge clk); // a stray extra item would show here.
		$display("%0d items checked, %0d mismatches, %0d idle errors",
			checked, errors, idle_errors);
		if (errors == 0 && idle_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* test/misc_branch_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "misc_cfg.svh"

module misc_branch_checker (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  logic in_ready,
	input  logic [`MISC_DEST_WIDTH-1:0] dest,
	input  logic signed [`MISC_FULL_WIDTH-1:0] exp_result,
	input  logic out_valid,
	input  logic out_ready,
	input  logic signed [`MISC_FULL_WIDTH-1:0] result,
	input  logic [`MISC_DEST_WIDTH-1:0] dest_out,
	output int checked,
	output int errors,
	output int idle_errors
);
	logic signed [`MISC_FULL_WIDTH-1:0] exp_q [$];
	logic [`MISC_DEST_WIDTH-1:0] dest_q [$];
	logic idle; // nothing taken since reset.

	// both ports are sampled at the edge, before the DUT registers move.
	always @(posedge clk) begin : compare
		logic signed [`MISC_FULL_WIDTH-1:0] want;
		logic [`MISC_DEST_WIDTH-1:0] want_dest;
		if (reset) begin
			exp_q.delete();
			dest_q.delete();
			errors = 0;
			checked = 0;
			idle_errors = 0;
			idle = 1'b1;
		end else begin
			if (idle) begin
				if (out_valid || !in_ready) begin
					$display("CHECK FAILED at %0t: not idle after reset, out_valid %b in_ready %b",
						$time, out_valid, in_ready);
					idle_errors = idle_errors + 1;
				end
				if (in_valid && in_ready) begin
					$display("idle after reset: %s", (idle_errors == 0) ? "ok" : "failed");
					idle = 1'b0;
				end
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					$display("Error at %0t: the DUT delivered an item that was never sent (%0d)",
						$time, result);
					errors = errors + 1;
				end else begin
					want = exp_q.pop_front();
					want_dest = dest_q.pop_front();
					if (result !== want || dest_out !== want_dest) begin
						$display("CHECK FAILED at %0t: item %0d expected %0d dest %0d, got %0d dest %0d",
							$time, checked, want, want_dest, result, dest_out);
						errors = errors + 1;
					end else begin
						$display("item %0d: result %0d dest %0d ok", checked, result, dest_out);
					end
					checked = checked + 1;
				end
			end
			if (in_valid && in_ready) begin
				exp_q.push_back(exp_result); // same order as the pipeline.
				dest_q.push_back(dest);
			end
		end
	end

endmodule

`default_nettype wire

/* logic/misc_branch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "misc_cfg.svh"

module misc_branch (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	output logic in_ready,
	input  misc_pkg::misc_op_e op,
	input  logic signed [`MISC_DATA_WIDTH-1:0] arg_a,
	input  logic signed [`MISC_DATA_WIDTH-1:0] arg_b,
	input  logic signed [`MISC_DATA_WIDTH-1:0] arg_c,
	input  misc_pkg::acc_word_u accumulator,
	input  logic [`MISC_SHIFT_WIDTH-1:0] shift,
	input  logic [`MISC_DEST_WIDTH-1:0] dest,
	output logic out_valid,
	input  logic out_ready,
	output logic signed [`MISC_FULL_WIDTH-1:0] result,
	output logic [`MISC_DEST_WIDTH-1:0] dest_out
);
	import misc_pkg::*;

	// operand stage to shift and clamp stage.
	logic s1_valid;
	logic s2_ready;
	misc_op_e s1_op;
	logic signed [`MISC_DATA_WIDTH-1:0] s1_abs;
	logic signed [`MISC_DATA_WIDTH-1:0] s1_min;
	logic signed [`MISC_DATA_WIDTH-1:0] s1_max;
	logic signed [`MISC_DATA_WIDTH-1:0] s1_lsh;
	logic signed [`MISC_DATA_WIDTH-1:0] s1_rsh;
	logic signed [`MISC_DATA_WIDTH-1:0] s1_lo;
	logic signed [`MISC_DATA_WIDTH-1:0] s1_hi;
	logic signed [`MISC_DATA_WIDTH-1:0] s1_arg;
	logic signed [`MISC_FULL_WIDTH-1:0] s1_acc;
	logic signed [`MISC_DATA_WIDTH-1:0] s1_upper;
	logic signed [`MISC_DATA_WIDTH-1:0] s1_lower;
	logic [1:0] s1_fine;
	logic [`MISC_DEST_WIDTH-1:0] s1_dest;

	// shift and clamp stage to result stage.
	logic s2_valid;
	logic s3_ready;
	misc_op_e s2_op;
	logic signed [`MISC_DATA_WIDTH-1:0] s2_lsh;
	logic signed [`MISC_DATA_WIDTH-1:0] s2_rsh;
	logic signed [`MISC_DATA_WIDTH-1:0] s2_clamp;
	logic signed [`MISC_DATA_WIDTH-1:0] s2_abs;
	logic signed [`MISC_DATA_WIDTH-1:0] s2_min;
	logic signed [`MISC_DATA_WIDTH-1:0] s2_max;
	logic signed [`MISC_FULL_WIDTH-1:0] s2_acc;
	logic signed [`MISC_DATA_WIDTH-1:0] s2_upper;
	logic signed [`MISC_DATA_WIDTH-1:0] s2_lower;
	logic [`MISC_DEST_WIDTH-1:0] s2_dest;

	misc_operand_stage operand_stage_inst (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready),
		.op(op), .arg_a(arg_a), .arg_b(arg_b), .arg_c(arg_c),
		.accumulator(accumulator), .shift(shift), .dest(dest),
		.out_valid(s1_valid), .out_ready(s2_ready),
		.op_out(s1_op), .abs_val(s1_abs), .min_val(s1_min), .max_val(s1_max),
		.lsh_part(s1_lsh), .rsh_part(s1_rsh),
		.clamp_lo(s1_lo), .clamp_hi(s1_hi), .clamp_arg(s1_arg),
		.acc_moved(s1_acc), .acc_upper(s1_upper), .acc_lower(s1_lower),
		.shift_fine(s1_fine), .dest_out(s1_dest)
	);

	misc_shift_clamp_stage shift_clamp_stage_inst (
		.clk(clk), .reset(reset),
		.in_valid(s1_valid), .in_ready(s2_ready),
		.op(s1_op), .abs_val(s1_abs), .min_val(s1_min), .max_val(s1_max),
		.lsh_part(s1_lsh), .rsh_part(s1_rsh),
		.clamp_lo(s1_lo), .clamp_hi(s1_hi), .clamp_arg(s1_arg),
		.acc_moved(s1_acc), .acc_upper(s1_upper), .acc_lower(s1_lower),
		.shift_fine(s1_fine), .dest(s1_dest),
		.out_valid(s2_valid), .out_ready(s3_ready),
		.op_out(s2_op), .lsh_val_out(s2_lsh), .rsh_val_out(s2_rsh),
		.clamp_val_out(s2_clamp), .abs_val_out(s2_abs),
		.min_val_out(s2_min), .max_val_out(s2_max),
		.acc_moved_out(s2_acc), .acc_upper_out(s2_upper), .acc_lower_out(s2_lower),
		.dest_out(s2_dest)
	);

	misc_result_stage result_stage_inst (
		.clk(clk), .reset(reset),
		.in_valid(s2_valid), .in_ready(s3_ready),
		.op(s2_op), .lsh_val(s2_lsh), .rsh_val(s2_rsh),
		.abs_val(s2_abs), .min_val(s2_min), .max_val(s2_max), .clamp_val(s2_clamp),
		.acc_moved(s2_acc), .acc_upper(s2_upper), .acc_lower(s2_lower),
		.dest(s2_dest),
		.out_valid(out_valid), .out_ready(out_ready),
		.result(result), .dest_out(dest_out)
	);

endmodule

`default_nettype wire

/* logic/misc_result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "misc_cfg.svh"

module misc_result_stage (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	output logic in_ready,
	input  misc_pkg::misc_op_e op,
	input  logic signed [`MISC_DATA_WIDTH-1:0] lsh_val,
	input  logic signed [`MISC_DATA_WIDTH-1:0] rsh_val,
	input  logic signed [`MISC_DATA_WIDTH-1:0] abs_val,
	input  logic signed [`MISC_DATA_WIDTH-1:0] min_val,
	input  logic signed [`MISC_DATA_WIDTH-1:0] max_val,
	input  logic signed [`MISC_DATA_WIDTH-1:0] clamp_val,
	input  logic signed [`MISC_FULL_WIDTH-1:0] acc_moved,
	input  logic signed [`MISC_DATA_WIDTH-1:0] acc_upper,
	input  logic signed [`MISC_DATA_WIDTH-1:0] acc_lower,
	input  logic [`MISC_DEST_WIDTH-1:0] dest,
	output logic out_valid,
	input  logic out_ready,
	output logic signed [`MISC_FULL_WIDTH-1:0] result,
	output logic [`MISC_DEST_WIDTH-1:0] dest_out
);
	import misc_pkg::*;

	logic take_in;
	logic signed [`MISC_FULL_WIDTH-1:0] selected;

	assign in_ready = ~out_valid | out_ready;
	assign take_in  = in_valid & in_ready;

	// 16-bit sources are signed, so each assignment sign-extends.
	always_comb begin
		case (op)
			op_lsh:      selected = lsh_val;
			op_rsh:      selected = rsh_val; // extended as a 16-bit value.
			op_abs:      selected = abs_val;
			op_min:      selected = min_val;
			op_max:      selected = max_val;
			op_clamp:    selected = clamp_val;
			op_mov_acc:  selected = acc_moved;
			op_mov_uacc: selected = acc_upper;
			op_mov_lacc: selected = acc_lower;
			default:     selected = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			result    <= '0;
			dest_out  <= '0;
		end else if (take_in) begin
			out_valid <= 1'b1;
			result    <= selected;
			dest_out  <= dest;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// the opcode travels two stages untouched.
	a_known_op: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> op inside {op_lsh, op_rsh, op_abs, op_min, op_max, op_clamp,
			op_mov_acc, op_mov_uacc, op_mov_lacc});

endmodule

`default_nettype wire

/* logic/misc_shift_clamp_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "misc_cfg.svh"

module misc_shift_clamp_stage (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	output logic in_ready,
	input  misc_pkg::misc_op_e op,
	input  logic signed [`MISC_DATA_WIDTH-1:0] abs_val,
	input  logic signed [`MISC_DATA_WIDTH-1:0] min_val,
	input  logic signed [`MISC_DATA_WIDTH-1:0] max_val,
	input  logic signed [`MISC_DATA_WIDTH-1:0] lsh_part,
	input  logic signed [`MISC_DATA_WIDTH-1:0] rsh_part,
	input  logic signed [`MISC_DATA_WIDTH-1:0] clamp_lo,
	input  logic signed [`MISC_DATA_WIDTH-1:0] clamp_hi,
	input  logic signed [`MISC_DATA_WIDTH-1:0] clamp_arg,
	input  logic signed [`MISC_FULL_WIDTH-1:0] acc_moved,
	input  logic signed [`MISC_DATA_WIDTH-1:0] acc_upper,
	input  logic signed [`MISC_DATA_WIDTH-1:0] acc_lower,
	input  logic [1:0] shift_fine,
	input  logic [`MISC_DEST_WIDTH-1:0] dest,
	output logic out_valid,
	input  logic out_ready,
	output misc_pkg::misc_op_e op_out,
	output logic signed [`MISC_DATA_WIDTH-1:0] lsh_val_out,
	output logic signed [`MISC_DATA_WIDTH-1:0] rsh_val_out,
	output logic signed [`MISC_DATA_WIDTH-1:0] clamp_val_out,
	output logic signed [`MISC_DATA_WIDTH-1:0] abs_val_out,
	output logic signed [`MISC_DATA_WIDTH-1:0] min_val_out,
	output logic signed [`MISC_DATA_WIDTH-1:0] max_val_out,
	output logic signed [`MISC_FULL_WIDTH-1:0] acc_moved_out,
	output logic signed [`MISC_DATA_WIDTH-1:0] acc_upper_out,
	output logic signed [`MISC_DATA_WIDTH-1:0] acc_lower_out,
	output logic [`MISC_DEST_WIDTH-1:0] dest_out
);
	import misc_pkg::*;

	logic take_in;
	logic [`MISC_DATA_WIDTH-1:0] lsh_2;
	logic [`MISC_DATA_WIDTH-1:0] lsh_1;
	logic [`MISC_DATA_WIDTH-1:0] rsh_2;
	logic [`MISC_DATA_WIDTH-1:0] rsh_1;
	logic signed [`MISC_DATA_WIDTH-1:0] clamped;

	assign in_ready = ~out_valid | out_ready;
	assign take_in  = in_valid & in_ready;

	assign lsh_2 = shift_fine[1] ? ($unsigned(lsh_part) << 2) : $unsigned(lsh_part);
	assign lsh_1 = shift_fine[0] ? (lsh_2 << 1) : lsh_2;
	assign rsh_2 = shift_fine[1] ? ($unsigned(rsh_part) >> 2) : $unsigned(rsh_part);
	assign rsh_1 = shift_fine[0] ? (rsh_2 >> 1) : rsh_2;

	assign clamped = (clamp_arg < clamp_lo) ? clamp_lo :
		(clamp_arg > clamp_hi) ? clamp_hi : clamp_arg;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid     <= 1'b0;
			op_out        <= op_lsh;
			lsh_val_out   <= '0;
			rsh_val_out   <= '0;
			clamp_val_out <= '0;
			abs_val_out   <= '0;
			min_val_out   <= '0;
			max_val_out   <= '0;
			acc_moved_out <= '0;
			acc_upper_out <= '0;
			acc_lower_out <= '0;
			dest_out      <= '0;
		end else if (take_in) begin
			out_valid     <= 1'b1;
			op_out        <= op;
			lsh_val_out   <= lsh_1;
			rsh_val_out   <= rsh_1;
			clamp_val_out <= clamped;
			abs_val_out   <= abs_val;
			min_val_out   <= min_val;
			max_val_out   <= max_val;
			acc_moved_out <= acc_moved;
			acc_upper_out <= acc_upper;
			acc_lower_out <= acc_lower;
			dest_out      <= dest;
		end else if (out_ready) begin
			out_valid     <= 1'b0;
		end
	end

	// ordering is done upstream.
	a_bounds_ordered: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> clamp_lo <= clamp_hi);

endmodule

`default_nettype wire

/* logic/misc_operand_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "misc_cfg.svh"

module misc_operand_stage (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	output logic in_ready,
	input  misc_pkg::misc_op_e op,
	input  logic signed [`MISC_DATA_WIDTH-1:0] arg_a,
	input  logic signed [`MISC_DATA_WIDTH-1:0] arg_b,
	input  logic signed [`MISC_DATA_WIDTH-1:0] arg_c,
	input  misc_pkg::acc_word_u accumulator,
	input  logic [`MISC_SHIFT_WIDTH-1:0] shift,
	input  logic [`MISC_DEST_WIDTH-1:0] dest,
	output logic out_valid,
	input  logic out_ready,
	output misc_pkg::misc_op_e op_out,
	output logic signed [`MISC_DATA_WIDTH-1:0] abs_val,
	output logic signed [`MISC_DATA_WIDTH-1:0] min_val,
	output logic signed [`MISC_DATA_WIDTH-1:0] max_val,
	output logic signed [`MISC_DATA_WIDTH-1:0] lsh_part,
	output logic signed [`MISC_DATA_WIDTH-1:0] rsh_part,
	output logic signed [`MISC_DATA_WIDTH-1:0] clamp_lo,
	output logic signed [`MISC_DATA_WIDTH-1:0] clamp_hi,
	output logic signed [`MISC_DATA_WIDTH-1:0] clamp_arg,
	output logic signed [`MISC_FULL_WIDTH-1:0] acc_moved,
	output logic signed [`MISC_DATA_WIDTH-1:0] acc_upper,
	output logic signed [`MISC_DATA_WIDTH-1:0] acc_lower,
	output logic [1:0] shift_fine,
	output logic [`MISC_DEST_WIDTH-1:0] dest_out
);
	import misc_pkg::*;

	logic take_in;
	logic swap;
	logic [`MISC_DATA_WIDTH-1:0] lsh_8;
	logic [`MISC_DATA_WIDTH-1:0] lsh_4;
	logic [`MISC_DATA_WIDTH-1:0] rsh_8;
	logic [`MISC_DATA_WIDTH-1:0] rsh_4;

	assign in_ready = ~out_valid | out_ready;
	assign take_in  = in_valid & in_ready;

	assign swap = arg_c < arg_b; // bounds came in reversed.

	// coarse half of the shift, fine half in the next stage.
	assign lsh_8 = shift[3] ? ($unsigned(arg_a) << 8) : $unsigned(arg_a);
	assign lsh_4 = shift[2] ? (lsh_8 << 4) : lsh_8;
	assign rsh_8 = shift[3] ? ($unsigned(arg_a) >> 8) : $unsigned(arg_a);
	assign rsh_4 = shift[2] ? (rsh_8 >> 4) : rsh_8; // zero fill.

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid  <= 1'b0;
			op_out     <= op_lsh;
			abs_val    <= '0;
			min_val    <= '0;
			max_val    <= '0;
			lsh_part   <= '0;
			rsh_part   <= '0;
			clamp_lo   <= '0;
			clamp_hi   <= '0;
			clamp_arg  <= '0;
			acc_moved  <= '0;
			acc_upper  <= '0;
			acc_lower  <= '0;
			shift_fine <= '0;
			dest_out   <= '0;
		end else if (take_in) begin
			out_valid  <= 1'b1;
			op_out     <= op;
			abs_val    <= (arg_a < 0) ? -arg_a : arg_a; // -32768 stays as is.
			min_val    <= (arg_a < arg_b) ? arg_a : arg_b;
			max_val    <= (arg_a > arg_b) ? arg_a : arg_b;
			lsh_part   <= lsh_4;
			rsh_part   <= rsh_4;
			clamp_lo   <= swap ? arg_c : arg_b;
			clamp_hi   <= swap ? arg_b : arg_c;
			clamp_arg  <= arg_a;
			acc_moved  <= accumulator.word >>> `MISC_ACC_SHIFT;
			acc_upper  <= accumulator.fields.upper;
			acc_lower  <= accumulator.fields.lower;
			shift_fine <= shift[1:0];
			dest_out   <= dest;
		end else if (out_ready) begin
			out_valid  <= 1'b0;
		end
	end

	a_idle_after_reset: assert property (@(posedge clk) reset |=> !out_valid);

	// a stalled item must not change under the consumer.
	a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable({op_out, abs_val, min_val,
			max_val, lsh_part, rsh_part, clamp_lo, clamp_hi, clamp_arg, acc_moved,
			acc_upper, acc_lower, shift_fine, dest_out}));

endmodule

`default_nettype wire

/* logic/misc_pkg.sv */
`default_nettype none

`include "misc_cfg.svh"

package misc_pkg;

	typedef enum logic [3:0] {
		op_lsh      = 4'd0,
		op_rsh      = 4'd1,
		op_abs      = 4'd2,
		op_min      = 4'd3,
		op_max      = 4'd4,
		op_clamp    = 4'd5,
		op_mov_acc  = 4'd6,
		op_mov_uacc = 4'd7,
		op_mov_lacc = 4'd8
	} misc_op_e;

	// field view of the accumulator, msb first.
	typedef struct packed {
		logic signed [`MISC_GUARD_BITS-1:0] guard;
		logic signed [`MISC_DATA_WIDTH-1:0] upper;
		logic signed [`MISC_DATA_WIDTH-1:0] lower;
	} acc_fields_s;

	// whole word for the shifted move, fields for the half moves.
	typedef union packed {
		logic signed [`MISC_FULL_WIDTH-1:0] word;
		acc_fields_s fields;
	} acc_word_u;

endpackage

`default_nettype wire

/* include/misc_cfg.svh */
`ifndef MISC_CFG_SVH
`define MISC_CFG_SVH

// operand width of the signed data path.
`define MISC_DATA_WIDTH 16

// headroom above the upper and lower halves.
`define MISC_GUARD_BITS 8

// accumulator and result width.
`define MISC_FULL_WIDTH (2 * `MISC_DATA_WIDTH + `MISC_GUARD_BITS)

// accumulator move drops the fractional bits.
`define MISC_ACC_SHIFT (`MISC_DATA_WIDTH - 1)

// shift amounts 0 to 15.
`define MISC_SHIFT_WIDTH 4

`define MISC_DEST_WIDTH 4

`endif
